/* Makefile */
TOOL    = verilator
FLAGS   = --binary --timing -j 0
TOP     = mipsCoreTb
FLIST   = flist.f
BUILD   = obj_dir
LOG     = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: build
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation PASSED"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* flist.f */
+incdir+source
source/mipsIsaPkg.sv
source/mipsCtrlPkg.sv
source/ctrlIf.sv
source/instrDecoder.sv
source/regFile.sv
source/aluUnit.sv
source/pcUnit.sv
source/operandRouter.sv
source/mipsCore.sv
tests/mipsCoreTb.sv

/* source/aluUnit.sv */
////////////////////////////////////////
// integer ALU
// shifts act on operand b by shamt
// zero flag feeds the branch decision
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module aluUnit (
    ctrlIf.dp                  ctrl,
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    input  logic [4:0]         shamt,
    output logic [`XLEN-1:0]   result,
    output logic               zero
);
    import mipsCtrlPkg::*;

    logic lessThan;

    // signed compare for slt and slti
    assign lessThan = ($signed(a) < $signed(b));

    always_comb
    begin
        case (ctrl.aluOp)
            aluAdd:  result = a + b;            // no overflow trap
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSlt:  result = {{(`XLEN-1){1'b0}}, lessThan};
            aluSll:  result = b << shamt;
            aluSrl:  result = b >> shamt;       // logical, zero fill
            aluLui:  result = b << `IMM_W;      // immediate to upper half
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* source/ctrlIf.sv */
////////////////////////////////////////
// decoded control bundle of one instruction
// driven by the decoder, read by every datapath unit
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface ctrlIf;
    import mipsCtrlPkg::*;

    logic    regWrite;      // register file write enable
    regDstT  regDst;
    aluSrcT  aluSrc;        // ALU operand b
    aluOpT   aluOp;
    logic    memRead;       // load strobe
    logic    memWrite;      // store strobe
    wbSrcT   wbSrc;
    pcSrcT   pcSrc;

    modport dec (output regWrite, regDst, aluSrc, aluOp, memRead, memWrite, wbSrc, pcSrc);
    modport dp  (input  regWrite, regDst, aluSrc, aluOp, memRead, memWrite, wbSrc, pcSrc);

endinterface

`default_nettype wire

/* source/instrDecoder.sv */
////////////////////////////////////////
// main control and ALU control in one block
// opcode and funct go in, the whole control bundle comes out
// an unknown word gives the no-op bundle: no writes, PC+4
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module instrDecoder (
    input  logic              iRST,
    input  logic [`XLEN-1:0]  instr,
    ctrlIf.dec                ctrl
);
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    rFieldsT fields;

    assign fields = rFieldsT'(instr);

    always_comb
    begin
        // no-op bundle as the starting point
        ctrl.regWrite = 1'b0;
        ctrl.regDst   = dstRt;
        ctrl.aluSrc   = srcReg;
        ctrl.aluOp    = aluAdd;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.wbSrc    = wbAlu;
        ctrl.pcSrc    = pcNext;

        case (fields.opcode)
            rType:
            begin
                ctrl.regDst = dstRd;
                case (fields.funct)
                    fnAdd: begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluAdd; end
                    fnSub: begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluSub; end
                    fnAnd: begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluAnd; end
                    fnOr:  begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluOr;  end
                    fnSlt: begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluSlt; end
                    fnSll: begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluSll; end   // rt << shamt
                    fnSrl: begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluSrl; end
                    fnJr:  ctrl.pcSrc = pcReg;                                  // no writeback
                    default: ;                                                  // unknown funct, no-op
                endcase
            end

            ////////////////////////////////////////
            // immediates
            ////////////////////////////////////////
            opAddi: begin ctrl.regWrite = 1'b1; ctrl.aluSrc = srcSignImm; end
            opSlti:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = srcSignImm;
                ctrl.aluOp    = aluSlt;
            end
            opAndi:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = srcZeroImm;     // logical ops zero-extend
                ctrl.aluOp    = aluAnd;
            end
            opOri:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = srcZeroImm;
                ctrl.aluOp    = aluOr;
            end
            opLui:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = srcZeroImm;
                ctrl.aluOp    = aluLui;
            end

            // memory, address is rs + signed offset
            opLw:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = srcSignImm;
                ctrl.memRead  = 1'b1;
                ctrl.wbSrc    = wbMem;
            end
            opSw: begin ctrl.aluSrc = srcSignImm; ctrl.memWrite = 1'b1; end

            // branches compare rs and rt by subtraction
            opBeq: begin ctrl.aluOp = aluSub; ctrl.pcSrc = pcBeq; end
            opBne: begin ctrl.aluOp = aluSub; ctrl.pcSrc = pcBne; end

            opJ:   ctrl.pcSrc = pcJump;
            opJal:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = dstLink;        // $ra <= PC+4
                ctrl.wbSrc    = wbPc4;
                ctrl.pcSrc    = pcJump;
            end
            default: ;                          // unknown opcode, no-op
        endcase

        // nothing is written while the core is held in reset
        if (iRST)
        begin
            ctrl.regWrite = 1'b0;
            ctrl.memRead  = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/mipsCore.sv */
////////////////////////////////////////
// single-cycle MIPS core, top level
// one instruction retires per clock; instruction and data
// memories answer combinationally, stores commit at the edge
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module mipsCore (
    input  logic              iCLK,
    input  logic              iRST,
    output logic [`XLEN-1:0]  instrAddr,
    input  logic [`XLEN-1:0]  instrData,
    output logic [`XLEN-1:0]  dataAddr,
    output logic [`XLEN-1:0]  dataWrData,
    input  logic [`XLEN-1:0]  dataRdData,
    output logic              dataRead,
    output logic              dataWrite
);
    import mipsIsaPkg::*;

    rFieldsT                 rFields;
    logic [`XLEN-1:0]        pc;
    logic [`XLEN-1:0]        pc4;
    logic [`XLEN-1:0]        rsData;
    logic [`XLEN-1:0]        rtData;
    logic [`XLEN-1:0]        aluB;
    logic [`XLEN-1:0]        aluResult;
    logic                    zero;
    logic [`REG_ADDR_W-1:0]  wrAddr;
    logic [`XLEN-1:0]        wrData;

    ctrlIf ctrlBus ();

    assign rFields = rFieldsT'(instrData);

    ////////////////////////////////////////
    // control and datapath units
    ////////////////////////////////////////
    instrDecoder uDecoder (
        .iRST  (iRST),
        .instr (instrData),
        .ctrl  (ctrlBus)
    );

    regFile uRegFile (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .rsAddr (rFields.rs),
        .rtAddr (rFields.rt),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .wrEn   (ctrlBus.regWrite),
        .rsData (rsData),
        .rtData (rtData)
    );

    aluUnit uAlu (
        .ctrl   (ctrlBus),
        .a      (rsData),
        .b      (aluB),
        .shamt  (rFields.shamt),
        .result (aluResult),
        .zero   (zero)
    );

    operandRouter uRouter (
        .ctrl      (ctrlBus),
        .instr     (instrData),
        .rtData    (rtData),
        .aluResult (aluResult),
        .memData   (dataRdData),
        .pc4       (pc4),
        .aluB      (aluB),
        .wrAddr    (wrAddr),
        .wrData    (wrData)
    );

    pcUnit uPc (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .ctrl   (ctrlBus),
        .instr  (instrData),
        .zero   (zero),
        .rsData (rsData),
        .pc     (pc),
        .pc4    (pc4)
    );

    ////////////////////////////////////////
    // memory ports
    ////////////////////////////////////////
    assign instrAddr  = pc;
    assign dataAddr   = aluResult;          // rs + offset for lw/sw
    assign dataWrData = rtData;
    assign dataRead   = ctrlBus.memRead;
    assign dataWrite  = ctrlBus.memWrite;

endmodule

`default_nettype wire

/* source/mipsCtrlPkg.sv */
////////////////////////////////////////
// control encodings between decoder and datapath
// mux selects and the ALU operation code
////////////////////////////////////////
`default_nettype none

package mipsCtrlPkg;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr,
        aluSlt, aluSll, aluSrl,
        aluLui                          // b moved to the upper half
    } aluOpT;

    // next PC source
    typedef enum logic [2:0] {
        pcNext,                         // sequential, PC+4
        pcBeq,                          // taken when ALU zero
        pcBne,                          // taken when ALU not zero
        pcJump,                         // j / jal region jump
        pcReg                           // jr, target in rs
    } pcSrcT;

    typedef enum logic [1:0] {dstRt, dstRd, dstLink} regDstT;

    typedef enum logic [1:0] {srcReg, srcSignImm, srcZeroImm} aluSrcT;

    // register writeback source
    typedef enum logic [1:0] {wbAlu, wbMem, wbPc4} wbSrcT;

endpackage

`default_nettype wire

/* source/mipsIsaPkg.sv */
////////////////////////////////////////
// MIPS instruction set encodings
// opcode and funct values kept by the core, plus the
// R, I and J field layouts used to slice a fetched word
////////////////////////////////////////
`default_nettype none
`include "mips_defs.svh"

package mipsIsaPkg;

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        rType  = 6'h00,         // funct selects the operation
        opJ    = 6'h02,
        opJal  = 6'h03,
        opBeq  = 6'h04,
        opBne  = 6'h05,
        opAddi = 6'h08,
        opSlti = 6'h0A,
        opAndi = 6'h0C,
        opOri  = 6'h0D,
        opLui  = 6'h0F,
        opLw   = 6'h23,
        opSw   = 6'h2B
    } opcodeT;

    // R-type funct, bits 5:0
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2A
    } functT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [4:0]              shamt;
        functT                   funct;
    } rFieldsT;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        logic [`IMM_W-1:0]       imm;
    } iFieldsT;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [25:0]             index;     // word index inside the 256 MB region
    } jFieldsT;

endpackage

`default_nettype wire

/* source/mips_defs.svh */
////////////////////////////////////////
// global sizes and fixed addresses of the single-cycle MIPS core
// include wherever a width or the reset vector is needed
////////////////////////////////////////
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////
`define XLEN        32              // data and address width
`define REG_ADDR_W  5               // register index width
`define REG_COUNT   32              // general registers, $zero included
`define IMM_W       16              // immediate field of I-type words

////////////////////////////////////////
// fixed addresses and indices
////////////////////////////////////////
// start of .text, loaded into the PC while reset is held
`define RESET_PC    32'h0040_0000

`define LINK_REG    31              // $ra, target of jal

`endif

/* source/operandRouter.sv */
////////////////////////////////////////
// datapath muxes around the ALU and register file
// immediate extension, operand b, destination, writeback
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module operandRouter (
    ctrlIf.dp                       ctrl,
    input  logic [`XLEN-1:0]        instr,
    input  logic [`XLEN-1:0]        rtData,
    input  logic [`XLEN-1:0]        aluResult,
    input  logic [`XLEN-1:0]        memData,
    input  logic [`XLEN-1:0]        pc4,
    output logic [`XLEN-1:0]        aluB,
    output logic [`REG_ADDR_W-1:0]  wrAddr,
    output logic [`XLEN-1:0]        wrData
);
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    rFieldsT          rFields;
    iFieldsT          iFields;
    logic [`XLEN-1:0] signImm;
    logic [`XLEN-1:0] zeroImm;

    assign rFields = rFieldsT'(instr);
    assign iFields = iFieldsT'(instr);

    assign signImm = {{(`XLEN-`IMM_W){iFields.imm[`IMM_W-1]}}, iFields.imm};
    assign zeroImm = {{(`XLEN-`IMM_W){1'b0}}, iFields.imm};

    always_comb
    begin
        case (ctrl.aluSrc)
            srcSignImm: aluB = signImm;
            srcZeroImm: aluB = zeroImm;
            default:    aluB = rtData;
        endcase

        // destination register
        case (ctrl.regDst)
            dstRd:   wrAddr = rFields.rd;
            dstLink: wrAddr = `REG_ADDR_W'(`LINK_REG);
            default: wrAddr = rFields.rt;       // I-type results
        endcase

        case (ctrl.wbSrc)
            wbMem:   wrData = memData;
            wbPc4:   wrData = pc4;              // return address for jal
            default: wrData = aluResult;
        endcase
    end

endmodule

`default_nettype wire

/* source/pcUnit.sv */
////////////////////////////////////////
// program counter and next-PC selection
// new PC is taken one edge after the instruction
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module pcUnit (
    input  logic              iCLK,
    input  logic              iRST,
    ctrlIf.dp                 ctrl,
    input  logic [`XLEN-1:0]  instr,
    input  logic              zero,
    input  logic [`XLEN-1:0]  rsData,
    output logic [`XLEN-1:0]  pc,
    output logic [`XLEN-1:0]  pc4
);
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    iFieldsT          iFields;
    jFieldsT          jFields;
    logic [`XLEN-1:0] branchTarget;
    logic [`XLEN-1:0] jumpTarget;
    logic [`XLEN-1:0] nextPc;

    assign iFields = iFieldsT'(instr);
    assign jFields = jFieldsT'(instr);

    assign pc4 = pc + `XLEN'd4;
    // word offset, sign-extended, relative to PC+4
    assign branchTarget = pc4 + {{(`XLEN-`IMM_W-2){iFields.imm[`IMM_W-1]}}, iFields.imm, 2'b00};
    assign jumpTarget   = {pc4[`XLEN-1:28], jFields.index, 2'b00};   // keep region bits

    always_comb
    begin
        case (ctrl.pcSrc)
            pcNext:  nextPc = pc4;
            pcBeq:   nextPc = zero ? branchTarget : pc4;
            pcBne:   nextPc = zero ? pc4 : branchTarget;
            pcJump:  nextPc = jumpTarget;
            pcReg:   nextPc = rsData;           // jr
            default: nextPc = pc4;
        endcase
    end

    always_ff @(posedge iCLK)
    begin
        if (iRST)
            pc <= `RESET_PC;
        else
            pc <= nextPc;
    end

endmodule

`default_nettype wire

/* source/regFile.sv */
////////////////////////////////////////
// general purpose register file
// two combinational reads, one write at the clock edge
// $zero ignores writes and always reads as zero
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module regFile (
    input  logic                    iCLK,
    input  logic                    iRST,
    input  logic [`REG_ADDR_W-1:0]  rsAddr,
    input  logic [`REG_ADDR_W-1:0]  rtAddr,
    input  logic [`REG_ADDR_W-1:0]  wrAddr,
    input  logic [`XLEN-1:0]        wrData,
    input  logic                    wrEn,
    output logic [`XLEN-1:0]        rsData,
    output logic [`XLEN-1:0]        rtData
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // write lands at the edge, seen by the next instruction
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (wrEn && (wrAddr != '0))    // $zero stays zero
            regs[wrAddr] <= wrData;
    end

    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

`default_nettype wire

/* tests/mipsCoreTb.sv */
////////////////////////////////////////
// testbench for the single-cycle MIPS core
// runs a small program from the instruction memory model and
// checks every store against a table of expected values
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none
`include "mips_defs.svh"

module mipsCoreTb;

    localparam int          CLK_PERIOD    = 100;
    localparam int          DRIVE_DELAY   = 5;      // inputs change after the edge
    localparam int          RESET_CYCLES  = 10;
    localparam int          STORE_TIMEOUT = 200;    // cycles allowed per store
    localparam int          HALT_CYCLES   = 20;
    localparam int          MAX_STORES    = 16;
    localparam logic [31:0] DATA_BASE     = 32'h1001_0000;
    localparam logic [31:0] VAL_A         = 32'd100;
    localparam logic [31:0] VAL_B         = -32'sd23;

    logic              iCLK;
    logic              iRST;
    logic [`XLEN-1:0]  instrAddr;
    logic [`XLEN-1:0]  instrData;
    logic [`XLEN-1:0]  dataAddr;
    logic [`XLEN-1:0]  dataWrData;
    logic [`XLEN-1:0]  dataRdData;
    logic              dataRead;
    logic              dataWrite;

    logic [31:0] imem [128];
    logic [31:0] dmem [64];
    int          progLen;
    int          storeCount;
    int          jalIdx;        // index of jal for the link value
    int          seed;
    logic [31:0] rand0;
    logic [31:0] rand1;
    string       testName [MAX_STORES];
    logic [31:0] expAddr  [MAX_STORES];
    logic [31:0] expData  [MAX_STORES];

    mipsCore u_dut (
        .iCLK       (iCLK),
        .iRST       (iRST),
        .instrAddr  (instrAddr),
        .instrData  (instrData),
        .dataAddr   (dataAddr),
        .dataWrData (dataWrData),
        .dataRdData (dataRdData),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite)
    );

    initial
    begin
        iCLK = 1'b0;
        forever #(CLK_PERIOD / 2) iCLK = ~iCLK;
    end

    ////////////////////////////////////////
    // memory models
    ////////////////////////////////////////
    assign instrData  = imem[instrAddr[8:2]];                   // program at RESET_PC
    assign dataRdData = dataRead ? dmem[dataAddr[7:2]] : 'x;    // valid only on a load

    // reloaded while reset is held and written by stores at the edge
    always @(posedge iCLK)
    begin
        if (iRST)
        begin
            for (int k = 0; k < 64; k++)
                dmem[k] <= fillWord(k);
            dmem[0] <= rand0;
            dmem[1] <= rand1;
        end
        else if (dataWrite)
            dmem[dataAddr[7:2]] <= dataWrData;
    end

    function automatic logic [31:0] fillWord(int idx);
        return (DATA_BASE + 32'(idx * 4)) ^ 32'h5A5A_0F0F;  // full address folded in
    endfunction

    ////////////////////////////////////////
    // instruction encoders
    ////////////////////////////////////////
    function automatic logic [31:0] encR(int rs, int rt, int rd, int shamt, int funct);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct[5:0]};
    endfunction

    function automatic logic [31:0] encI(int op, int rs, int rt, int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // target given as word index into the program
    function automatic logic [31:0] encJ(int op, int target);
        logic [31:0] addr;
        addr = `RESET_PC + 32'(target * 4);
        return {op[5:0], addr[27:2]};
    endfunction

    task automatic put(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic addStore(input string name, input int offset, input logic [31:0] value);
        testName[storeCount] = name;
        expAddr[storeCount]  = DATA_BASE + 32'(offset);
        expData[storeCount]  = value;
        storeCount++;
    endtask

    task automatic loadProgram();
        for (int k = 0; k < 128; k++)
            imem[k] = 32'h0000_0000;               // sll $0,$0,0 acts as nop
        progLen = 0;
        put(encI('h0F, 0, 16, 'h1001));            // 0  lui $16, data base
        put(encI('h23, 16, 8, 0));                 // 1  lw $8, random word 0
        put(encI('h23, 16, 9, 4));                 // 2  lw $9, random word 1
        put(encR(8, 9, 10, 0, 'h20));              // 3  add $10
        put(encI('h2B, 16, 10, 8));
        put(encI('h08, 0, 11, 100));               // 5  addi $11 = 100
        put(encI('h08, 0, 12, -23));               // 6  addi $12 = -23
        put(encR(11, 12, 13, 0, 'h20));            // add
        put(encI('h2B, 16, 13, 12));
        put(encR(11, 12, 13, 0, 'h22));            // sub
        put(encI('h2B, 16, 13, 16));
        put(encI('h0D, 0, 14, 'hF0F0));            // 11 ori $14
        put(encR(14, 12, 13, 0, 'h24));            // and
        put(encI('h2B, 16, 13, 20));
        put(encR(14, 11, 13, 0, 'h25));            // or
        put(encI('h2B, 16, 13, 24));
        put(encR(12, 11, 13, 0, 'h2A));            // slt
        put(encI('h2B, 16, 13, 28));
        put(encR(0, 11, 13, 4, 'h00));             // sll by 4
        put(encI('h2B, 16, 13, 32));
        put(encR(0, 12, 13, 28, 'h02));            // srl by 28
        put(encI('h2B, 16, 13, 36));
        put(encI('h0F, 0, 13, 'hABCD));            // lui
        put(encI('h2B, 16, 13, 40));
        put(encI('h0D, 0, 13, 'h8001));            // ori with the imm top bit set
        put(encI('h2B, 16, 13, 44));
        put(encI('h0C, 12, 13, 'hFFF0));          // andi
        put(encI('h2B, 16, 13, 48));
        put(encI('h0A, 11, 13, -1));               // slti against -1
        put(encI('h2B, 16, 13, 52));
        put(encI('h04, 11, 12, 1));                // 30 beq not taken
        put(encI('h2B, 16, 11, 56));
        put(encI('h04, 11, 11, 1));                // 32 beq taken
        put(encI('h2B, 16, 0, 60));                // skipped marker
        put(encI('h05, 11, 11, 1));                // 34 bne not taken
        put(encI('h2B, 16, 12, 60));
        put(encI('h05, 11, 12, 1));                // 36 bne taken
        put(encI('h2B, 16, 0, 64));                // skipped marker
        put(encJ('h02, 40));                       // 38 j over the marker
        put(encI('h2B, 16, 0, 64));                // skipped marker
        jalIdx = progLen;
        put(encJ('h03, 43));                       // 40 jal
        put(encI('h2B, 16, 11, 68));               // 41 return point of jr
        put(encJ('h02, 42));                       // 42 park here
        put(encI('h2B, 16, 31, 64));               // 43 store $ra
        put(encR(31, 0, 0, 0, 'h08));              // 44 jr $ra
    endtask

    // expected stores in program order
    task automatic buildTable();
        storeCount = 0;
        addStore("load sum", 8, rand0 + rand1);
        addStore("add", 12, VAL_A + VAL_B);
        addStore("sub", 16, VAL_A - VAL_B);
        addStore("and", 20, 32'h0000_F0F0 & VAL_B);
        addStore("or", 24, 32'h0000_F0F0 | VAL_A);
        addStore("slt", 28, ($signed(VAL_B) < $signed(VAL_A)) ? 32'd1 : 32'd0);
        addStore("sll", 32, VAL_A << 4);
        addStore("srl", 36, VAL_B >> 28);
        addStore("lui", 40, 32'h0000_ABCD << 16);
        addStore("ori", 44, 32'h0000_8001);        // zero extended
        addStore("andi", 48, VAL_B & 32'h0000_FFF0);
        addStore("slti", 52, ($signed(VAL_A) < -32'sd1) ? 32'd1 : 32'd0);
        addStore("beq not taken", 56, VAL_A);
        addStore("bne not taken", 60, VAL_B);      // beq taken skipped its marker
        addStore("jal link", 64, `RESET_PC + 32'(4 * (jalIdx + 1)));
        addStore("jr return", 68, VAL_A);
    endtask

    ////////////////////////////////////////
    // checking
    ////////////////////////////////////////
    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
            stopOnError($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    endtask

    // samples at the falling edge, mid cycle
    task automatic waitStore(input string name);
        int cycles;
        cycles = 0;
        @(negedge iCLK);
        while (dataWrite !== 1'b1)
        begin
            cycles++;
            if (cycles >= STORE_TIMEOUT)
                stopOnError($sformatf("no store arrived within %0d cycles for test %s",
                                      STORE_TIMEOUT, name));
            @(negedge iCLK);
        end
    endtask

    initial
    begin
        iRST = 1'b1;
        seed = 32'h10fc1ff5;
        rand0 = $random(seed);
        rand1 = $random(seed);

        // a store and a load are fetched in turn while reset is held
        // nothing leaves the core during that time
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(posedge iCLK);
            #DRIVE_DELAY;
            imem[0] = (i % 2 == 0) ? encI('h2B, 0, 0, 0) : encI('h23, 0, 0, 0);
            @(negedge iCLK);
            checkValue("reset dataRead", 32'd0, {31'd0, dataRead});
            checkValue("reset dataWrite", 32'd0, {31'd0, dataWrite});
            checkValue("reset instrAddr", `RESET_PC, instrAddr);
        end
        @(posedge iCLK);
        #DRIVE_DELAY;
        loadProgram();
        buildTable();
        iRST = 1'b0;
        @(negedge iCLK);
        checkValue("first fetch", `RESET_PC, instrAddr);

        for (int i = 0; i < storeCount; i++)
        begin
            waitStore(testName[i]);
            checkValue({testName[i], " address"}, expAddr[i], dataAddr);
            checkValue({testName[i], " data"}, expData[i], dataWrData);
        end

        // no further stores once parked in the j loop
        for (int i = 0; i < HALT_CYCLES; i++)
        begin
            @(negedge iCLK);
            checkValue("halt dataWrite", 32'd0, {31'd0, dataWrite});
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
